//--- axi_read_master.f
axi_rd_pkg.sv
rd_request_setup.sv
ar_issuer.sv
r_beat_fifo.sv
burst_ledger.sv
axi_read_master.sv
tb_axi_read_master.sv

//--- tb_axi_read_master.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the read master
// A memory slave model with random AR ready and random R gaps answers the
// read requests, the stream side sees random back-pressure, and every
// stream beat is compared with a reference model of rounding, alignment
// and burst splitting
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_axi_read_master import axi_rd_pkg::*; ();

  // 40 cycles per beat over all tests (25 + 2 + 750 + 1536) plus margin
  localparam int CYCLE_LIMIT = 40 * (25 + 2 + 750 + 1536) + 2000;

  logic      aclk;
  logic      areset;
  logic      ctrl_start;
  xfer_cmd_t ctrl_cmd;
  logic      ctrl_done;
  logic      m_axi_arvalid;
  logic      m_axi_arready;
  ar_req_t   m_axi_ar;
  logic      m_axi_rvalid;
  logic      m_axi_rready;
  r_beat_t   m_axi_r;
  logic      m_axis_tvalid;
  logic      m_axis_tready;
  r_beat_t   m_axis_t;

  // Slave model and random source
  ar_req_t     ar_q[$];
  int          r_beat_idx;
  logic [15:0] lfsr;
  int          hold_left;
  // Expectations of the running test
  xfer_cmd_t   cur_cmd;
  int          exp_beats;
  int          exp_bursts;
  int          beat_idx;
  int          ar_idx;
  int          drained;
  int          r_last_count;
  int          done_count;
  // Totals
  int          err_count;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;

  axi_read_master uut (
    .aclk          (aclk),
    .areset        (areset),
    .ctrl_start    (ctrl_start),
    .ctrl_cmd      (ctrl_cmd),
    .ctrl_done     (ctrl_done),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_ar      (m_axi_ar),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready),
    .m_axi_r       (m_axi_r),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_t      (m_axis_t)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory contents and reference model
  ////////////////////////////////////////////////////////////////////////////
  // Odd multiplier makes every address bit show in the word
  function automatic logic [DATA_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
    mem_word = (addr * 32'h9E37_79B1) ^ 32'h5A5A_F00D;
  endfunction

  // Partial words round up to a whole beat
  function automatic int ref_beats(input xfer_cmd_t c);
    ref_beats = (int'(c.xfer_size) + DW_BYTES - 1) / DW_BYTES;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] ref_base(input xfer_cmd_t c);
    ref_base = (c.addr_offset / BURST_BYTES) * BURST_BYTES;
  endfunction

  // Beat k comes from base + 4k and is last at each burst end and on the final beat
  function automatic r_beat_t ref_beat(input xfer_cmd_t c, input int k);
    ref_beat.data = mem_word(ref_base(c) + ADDR_WIDTH'(DW_BYTES * k));
    ref_beat.last = ((k + 1) % BURST_LEN == 0) || (k == ref_beats(c) - 1);
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [3:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits[i] = lfsr[0];
    end
  endtask

  task automatic log_error(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    err_count++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Slave model driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge aclk) begin : slave_driver
    logic [3:0] bits;
    // rready is high out of reset, so a driven beat was taken at the last edge
    if (m_axi_rvalid) begin
      if (r_beat_idx == int'(ar_q[0].arlen)) begin
        void'(ar_q.pop_front());
        r_beat_idx = 0;
      end else begin
        r_beat_idx++;
      end
    end
    // One in four cycles holds off the address channel
    take_bits(2, bits);
    m_axi_arready = (bits[1:0] != 2'b00);
    // Three in four cycles carry a beat when one is ready
    take_bits(2, bits);
    if (ar_q.size() != 0 && bits[1:0] != 2'b00) begin
      m_axi_rvalid = 1'b1;
      m_axi_r.data = mem_word(ar_q[0].araddr + ADDR_WIDTH'(DW_BYTES * r_beat_idx));
      m_axi_r.last = (r_beat_idx == int'(ar_q[0].arlen));
    end else begin
      m_axi_rvalid = 1'b0;
    end
    if (hold_left > 0) begin
      m_axis_tready = 1'b0;
      hold_left--;
    end else begin
      take_bits(2, bits);
      m_axis_tready = (bits[1:0] != 2'b00);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checker sampling handshakes at the rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge aclk) begin : handshake_check
    r_beat_t               exp;
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [7:0]            exp_len;
    if (!areset) begin
      // Final R last was counted at an earlier edge
      if (ctrl_done) begin
        done_count++;
        if (r_last_count != exp_bursts)
          log_error($sformatf("ctrl_done after %0d of %0d R bursts", r_last_count, exp_bursts));
      end
      if (m_axi_rvalid && !m_axi_rready)
        log_error("R beat offered while rready is low");
      if (m_axi_rvalid && m_axi_rready && m_axi_r.last) r_last_count++;
      if (m_axi_arvalid && m_axi_arready) begin
        ar_q.push_back(m_axi_ar);
        exp_addr = ref_base(cur_cmd) + ADDR_WIDTH'(BURST_BYTES * ar_idx);
        exp_len  = (ar_idx == exp_bursts - 1) ? 8'((exp_beats - 1) % BURST_LEN) : 8'(BURST_LEN - 1);
        if (ar_idx >= exp_bursts)
          log_error($sformatf("extra AR request %0d", ar_idx));
        else if (m_axi_ar.araddr !== exp_addr || m_axi_ar.arlen !== exp_len)
          log_error($sformatf("AR %0d got %h/%0d, expected %h/%0d", ar_idx,
                              m_axi_ar.araddr, m_axi_ar.arlen, exp_addr, exp_len));
        ar_idx++;
        if (ar_idx - drained > MAX_OUTSTANDING)
          log_error($sformatf("%0d bursts outstanding", ar_idx - drained));
      end
      if (m_axis_tvalid && m_axis_tready) begin
        exp = ref_beat(cur_cmd, beat_idx);
        if (beat_idx >= exp_beats)
          log_error($sformatf("extra stream beat %0d", beat_idx));
        else if (m_axis_t.data !== exp.data || m_axis_t.last !== exp.last)
          log_error($sformatf("beat %0d got %h/%b, expected %h/%b", beat_idx,
                              m_axis_t.data, m_axis_t.last, exp.data, exp.last));
        if (m_axis_t.last) drained++;
        beat_idx++;
      end
    end
  end

  // Starts one transfer and waits for done plus the last stream beat
  task automatic run_transfer(input string name, input logic [ADDR_WIDTH-1:0] addr,
                              input int bytes, input int hold);
    int errs_before;
    errs_before = err_count;
    @(posedge aclk);
    hold_left = hold;
    @(negedge aclk);
    cur_cmd      = '{addr_offset: addr, xfer_size: XFER_SIZE_WIDTH'(bytes)};
    exp_beats    = ref_beats(cur_cmd);
    exp_bursts   = (exp_beats + BURST_LEN - 1) / BURST_LEN;
    beat_idx     = 0;
    ar_idx       = 0;
    drained      = 0;
    r_last_count = 0;
    done_count   = 0;
    ctrl_cmd     = cur_cmd;
    ctrl_start   = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
    while (beat_idx < exp_beats || done_count == 0) @(negedge aclk);
    // Quiet tail to catch a late second done or stray beats
    repeat (16) @(negedge aclk);
    if (ar_idx != exp_bursts)
      log_error($sformatf("%0d AR requests, expected %0d", ar_idx, exp_bursts));
    if (done_count != 1)
      log_error($sformatf("ctrl_done pulsed %0d times", done_count));
    if (err_count == errs_before) tests_passed++;
    else tests_failed++;
    $display("%s: %0d beats, %0d bursts, %0d errors", name, beat_idx, ar_idx,
             err_count - errs_before);
  endtask

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge aclk);
      cycle_count++;
    end
    $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_cmd      = '0;
    m_axi_arready = 1'b1;
    m_axi_rvalid  = 1'b0;
    m_axi_r       = '0;
    m_axis_tready = 1'b0;
    lfsr          = 16'd30;
    hold_left     = 0;
    r_beat_idx    = 0;
    err_count     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    repeat (2) @(negedge aclk);
    areset = 1'b0;
    run_transfer("aligned 100 bytes", 32'h0000_4000, 100, 0);
    run_transfer("unaligned 6 bytes", 32'h0000_2345, 6, 0);
    run_transfer("three bursts", 32'h0001_0000, 3000, 0);
    run_transfer("stream stalled", 32'h0002_0400, 6144, 3000);
    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_axi_read_master

`default_nettype wire

//--- axi_read_master.sv
////////////////////////////////////////////////////////////////////////////
// Read master top level
// A ctrl_start pulse with address and byte count reads memory in bursts
// and returns the beats on the stream port; ctrl_done marks the last beat
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module axi_read_master import axi_rd_pkg::*; (
  input  wire            aclk,
  input  wire            areset,
  input  wire            ctrl_start,
  input  wire xfer_cmd_t ctrl_cmd,
  output logic           ctrl_done,
  output logic           m_axi_arvalid,
  input  wire            m_axi_arready,
  output ar_req_t        m_axi_ar,
  input  wire            m_axi_rvalid,
  output logic           m_axi_rready,
  input  wire r_beat_t   m_axi_r,
  output logic           m_axis_tvalid,
  input  wire            m_axis_tready,
  output r_beat_t        m_axis_t
);

  burst_plan_t plan;
  logic        plan_start;
  logic        ar_stall;
  logic        ar_accept;
  logic        r_xfer;
  logic        r_burst_end;
  logic        stream_burst_end;

  // FIFO holds every outstanding burst, so R is always accepted
  assign m_axi_rready     = ~areset;
  assign r_xfer           = m_axi_rvalid & m_axi_rready;
  assign r_burst_end      = r_xfer & m_axi_r.last;
  assign stream_burst_end = m_axis_tvalid & m_axis_tready & m_axis_t.last;

  rd_request_setup u_setup (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_cmd   (ctrl_cmd),
    .plan       (plan),
    .plan_start (plan_start)
  );

  ar_issuer u_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .plan          (plan),
    .plan_start    (plan_start),
    .ar_stall      (ar_stall),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_ar      (m_axi_ar),
    .ar_accept     (ar_accept)
  );

  r_beat_fifo u_fifo (
    .aclk     (aclk),
    .areset   (areset),
    .wr_en    (r_xfer),
    .wr_beat  (m_axi_r),
    .rd_en    (m_axis_tready),
    .rd_beat  (m_axis_t),
    .rd_valid (m_axis_tvalid)
  );

  burst_ledger u_ledger (
    .aclk             (aclk),
    .areset           (areset),
    .plan             (plan),
    .plan_start       (plan_start),
    .ar_accept        (ar_accept),
    .r_burst_end      (r_burst_end),
    .stream_burst_end (stream_burst_end),
    .ar_stall         (ar_stall),
    .ctrl_done        (ctrl_done)
  );

endmodule : axi_read_master

`default_nettype wire

//--- burst_ledger.sv
////////////////////////////////////////////////////////////////////////////
// Burst bookkeeping between address side and data side
// Counts free outstanding slots to stall the AR channel and counts R
// bursts down to raise a one-cycle done after the final one
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module burst_ledger import axi_rd_pkg::*; (
  input  wire              aclk,
  input  wire              areset,
  input  wire burst_plan_t plan,
  input  wire              plan_start,
  input  wire              ar_accept,
  input  wire              r_burst_end,
  input  wire              stream_burst_end,
  output logic             ar_stall,
  output logic             ctrl_done
);

  logic [OUTSTANDING_WIDTH-1:0] vacancy;
  logic [BURST_CNT_WIDTH-1:0]   r_bursts_left;
  logic                         r_active;
  logic                         r_final;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding slots
  ////////////////////////////////////////////////////////////////////////////
  // Slot taken by an AR handshake, freed once its burst leaves the stream
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= OUTSTANDING_WIDTH'(MAX_OUTSTANDING);
    end else begin
      case ({ar_accept, stream_burst_end})
        2'b10:   vacancy <= vacancy - 1'b1;
        2'b01:   vacancy <= vacancy + 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

  assign ar_stall = (vacancy == '0);

  ////////////////////////////////////////////////////////////////////////////
  // R burst countdown and done
  ////////////////////////////////////////////////////////////////////////////
  assign r_final = r_active & r_burst_end & (r_bursts_left == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      r_active      <= 1'b0;
      r_bursts_left <= '0;
      ctrl_done     <= 1'b0;
    end else begin
      ctrl_done <= r_final;
      if (plan_start) begin
        r_active      <= 1'b1;
        r_bursts_left <= plan.last_burst;
      end else if (r_final) begin
        r_active <= 1'b0;
      end else if (r_active && r_burst_end) begin
        r_bursts_left <= r_bursts_left - 1'b1;
      end
    end
  end

  // Stream never drains more bursts than were issued
  a_vacancy_max : assert property (@(posedge aclk) disable iff (areset)
    vacancy <= OUTSTANDING_WIDTH'(MAX_OUTSTANDING));

endmodule : burst_ledger

`default_nettype wire

//--- r_beat_fifo.sv
////////////////////////////////////////////////////////////////////////////
// First-word-fall-through FIFO for read beats
// The head entry sits in its own register and is shown on rd_beat while
// rd_valid is high; rd_en pops it. Sized to hold all outstanding bursts
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module r_beat_fifo import axi_rd_pkg::*; (
  input  wire          aclk,
  input  wire          areset,
  input  wire          wr_en,
  input  wire r_beat_t wr_beat,
  input  wire          rd_en,
  output r_beat_t      rd_beat,
  output logic         rd_valid
);

  r_beat_t                   mem [FIFO_DEPTH];
  logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
  // Entries in the array, head register not included
  logic [FIFO_PTR_WIDTH:0]   mem_count;
  logic                      pop;
  logic                      head_free;
  logic                      load_from_mem;
  logic                      bypass;
  logic                      wr_to_mem;
  logic                      full;

  assign pop           = rd_en & rd_valid;
  // Head empty or leaving this cycle
  assign head_free     = ~rd_valid | pop;
  assign load_from_mem = head_free & (mem_count != '0);
  // Empty FIFO, new beat goes straight to the head
  assign bypass        = head_free & (mem_count == '0) & wr_en;
  assign wr_to_mem     = wr_en & ~bypass;
  assign full          = (mem_count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));

  // Storage array
  always_ff @(posedge aclk) begin
    if (wr_to_mem) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // Head register
  always_ff @(posedge aclk) begin
    if (load_from_mem) begin
      rd_beat <= mem[rd_ptr];
    end else if (bypass) begin
      rd_beat <= wr_beat;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      mem_count <= '0;
      rd_valid  <= 1'b0;
    end else begin
      if (wr_to_mem) wr_ptr <= wr_ptr + 1'b1;
      if (load_from_mem) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_to_mem, load_from_mem})
        2'b10:   mem_count <= mem_count + 1'b1;
        2'b01:   mem_count <= mem_count - 1'b1;
        default: mem_count <= mem_count;
      endcase
      if (head_free) rd_valid <= load_from_mem | bypass;
    end
  end

  // Outstanding limit upstream keeps the array from overflowing
  a_no_overflow : assert property (@(posedge aclk) disable iff (areset)
    wr_en && full |-> load_from_mem);

endmodule : r_beat_fifo

`default_nettype wire

//--- ar_issuer.sv
////////////////////////////////////////////////////////////////////////////
// Read-address channel driver
// Loaded by plan_start, issues one AR request per burst, stepping the
// address by a full burst each time, and holds back while ar_stall is high
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module ar_issuer import axi_rd_pkg::*; (
  input  wire              aclk,
  input  wire              areset,
  input  wire burst_plan_t plan,
  input  wire              plan_start,
  input  wire              ar_stall,
  output logic             m_axi_arvalid,
  input  wire              m_axi_arready,
  output ar_req_t          m_axi_ar,
  output logic             ar_accept
);

  logic                       idle;
  logic [ADDR_WIDTH-1:0]      addr;
  logic [BURST_CNT_WIDTH-1:0] bursts_left;
  logic                       final_burst;
  logic                       issue_ok;

  assign ar_accept   = m_axi_arvalid & m_axi_arready;
  assign final_burst = (bursts_left == '0);
  // Work pending and room for another burst
  assign issue_ok    = (plan_start | ~idle) & ~ar_stall;

  ////////////////////////////////////////////////////////////////////////////
  // Valid and idle control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (!m_axi_arvalid) begin
      m_axi_arvalid <= issue_ok;
    end else if (m_axi_arready) begin
      // One idle cycle so the stall sees the updated vacancy
      m_axi_arvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      idle        <= 1'b1;
      bursts_left <= '0;
    end else if (plan_start) begin
      idle        <= 1'b0;
      bursts_left <= plan.last_burst;
    end else if (ar_accept) begin
      if (final_burst) begin
        idle <= 1'b1;
      end else begin
        bursts_left <= bursts_left - 1'b1;
      end
    end
  end

  // Address steps one full burst per accept
  always_ff @(posedge aclk) begin
    if (plan_start) begin
      addr <= plan.base_addr;
    end else if (ar_accept) begin
      addr <= addr + ADDR_WIDTH'(BURST_BYTES);
    end
  end

  // Only the last burst is short
  assign m_axi_ar = '{
    araddr: addr,
    arlen:  final_burst ? 8'(plan.final_len) : 8'(BURST_LEN - 1)
  };

  // Request held steady until the slave takes it
  a_ar_stable : assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_ar));

endmodule : ar_issuer

`default_nettype wire

//--- rd_request_setup.sv
////////////////////////////////////////////////////////////////////////////
// Front end of the read master
// Samples the command on ctrl_start, rounds the byte count up to words,
// aligns the address down to a burst boundary and splits the word count
// into a burst plan, announced by plan_start two cycles later
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module rd_request_setup import axi_rd_pkg::*; (
  input  wire              aclk,
  input  wire              areset,
  input  wire              ctrl_start,
  input  wire xfer_cmd_t   ctrl_cmd,
  output burst_plan_t      plan,
  output logic             plan_start
);

  logic [TOTAL_LEN_WIDTH-1:0] size_words;
  logic                       partial_word;
  logic [TOTAL_LEN_WIDTH-1:0] total_len_r;
  logic [ADDR_WIDTH-1:0]      base_addr_r;
  logic                       start_d1;

  // Whole words in the byte count
  assign size_words   = ctrl_cmd.xfer_size[LOG_DW_BYTES +: TOTAL_LEN_WIDTH];
  // Leftover bytes need one more word
  assign partial_word = |ctrl_cmd.xfer_size[LOG_DW_BYTES-1:0];

  // Command capture, held until the next start
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Stored as words minus one, same convention as arlen
      total_len_r <= partial_word ? size_words : size_words - 1'b1;
      base_addr_r <= ctrl_cmd.addr_offset & ~ADDR_WIDTH'(BURST_BYTES - 1);
    end
  end

  // Upper bits count full bursts, lower bits give the final arlen
  assign plan = '{
    base_addr:  base_addr_r,
    last_burst: total_len_r[LOG_BURST_LEN +: BURST_CNT_WIDTH],
    final_len:  total_len_r[LOG_BURST_LEN-1:0]
  };

  // Two-stage start delay
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1   <= 1'b0;
      plan_start <= 1'b0;
    end else begin
      start_d1   <= ctrl_start;
      plan_start <= start_d1;
    end
  end

endmodule : rd_request_setup

`default_nettype wire

//--- axi_rd_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, burst constants and payload structs for the read master
// Every RTL module and the testbench pull this in by wildcard import
// Changing DATA_WIDTH or MAX_OUTSTANDING resizes the bursts and the FIFO
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package axi_rd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and transfer widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int DW_BYTES        = DATA_WIDTH / 8;
  localparam int LOG_DW_BYTES    = $clog2(DW_BYTES);
  localparam int XFER_SIZE_WIDTH = 20;
  // Word count of a transfer, minus one
  localparam int TOTAL_LEN_WIDTH = XFER_SIZE_WIDTH - LOG_DW_BYTES;

  // Burst limited by 4 KB boundary and by 256 beats
  localparam int BURST_LEN       = (4096 / DW_BYTES < 256) ? 4096 / DW_BYTES : 256;
  localparam int LOG_BURST_LEN   = $clog2(BURST_LEN);
  localparam int BURST_BYTES     = BURST_LEN * DW_BYTES;
  localparam int BURST_CNT_WIDTH = TOTAL_LEN_WIDTH - LOG_BURST_LEN;

  // Outstanding limit, also sets FIFO size
  localparam int MAX_OUTSTANDING   = 4;
  localparam int OUTSTANDING_WIDTH = $clog2(MAX_OUTSTANDING + 1);
  localparam int FIFO_DEPTH        = 2 ** $clog2(BURST_LEN * MAX_OUTSTANDING);
  localparam int FIFO_PTR_WIDTH    = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////////////////////
  // Payload structs
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      addr_offset;
    logic [XFER_SIZE_WIDTH-1:0] xfer_size;
  } xfer_cmd_t;

  // last_burst is bursts minus one, final_len is arlen of the last burst
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      base_addr;
    logic [BURST_CNT_WIDTH-1:0] last_burst;
    logic [LOG_BURST_LEN-1:0]   final_len;
  } burst_plan_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] araddr;
    logic [7:0]            arlen;
  } ar_req_t;

  // Same beat format on R channel, FIFO and stream
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } r_beat_t;

endpackage : axi_rd_pkg

`default_nettype wire
